// ==== design/fillCounter.sv ====
`timescale 1ns/1ps
`include "scanLink_defines.svh"

module fillCounter (
	input  logic                clk,
	input  logic                rst,
	input  logic                countEnable,
	input  logic                bufferClear,
	output scanPkg::fillLevel_t fillLevel,
	output logic                fillStep
);

	localparam int DivWidth = $clog2(`SLOW_DIV);
	localparam logic [DivWidth-1:0] DivLast = DivWidth'(`SLOW_DIV - 1);

	logic [DivWidth-1:0] divCount;
	logic                divWrap;

	assign divWrap = countEnable && (divCount == DivLast);

	// Held at zero while not scanning so every pass starts in phase
	always_ff @(posedge clk) begin
		if (rst || bufferClear || !countEnable) begin
			divCount <= '0;
		end else if (divWrap) begin
			divCount <= '0;
		end else begin
			divCount <= divCount + 1'b1;
		end
	end

	// Fake buffer fill, one level per divider wrap
	always_ff @(posedge clk) begin
		if (rst || bufferClear) begin
			fillLevel <= '0;
			fillStep  <= 1'b0;
		end else if (divWrap && (fillLevel < `FILL_FULL)) begin
			fillLevel <= fillLevel + 1'b1;
			fillStep  <= 1'b1;  // Aligned with the new level
		end else begin
			fillStep <= 1'b0;  // No strobe once saturated
		end
	end

endmodule

// ==== design/frameQueue.sv ====
`timescale 1ns/1ps
`include "scanLink_defines.svh"

module frameQueue (
	input  logic                clk,
	input  logic                rst,
	input  logic                push,
	input  scanPkg::linkFrame_t pushFrame,
	input  logic                pop,
	output scanPkg::linkFrame_t headFrame,
	output logic                notEmpty
);
	import scanPkg::*;

	localparam int PtrWidth = $clog2(`QUEUE_DEPTH);
	localparam logic [PtrWidth-1:0] PtrLast = PtrWidth'(`QUEUE_DEPTH - 1);

	linkFrame_t          entries [`QUEUE_DEPTH];
	logic [PtrWidth-1:0] wrPtr;
	logic [PtrWidth-1:0] rdPtr;
	logic [PtrWidth:0]   count;
	logic                doPop;

	function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
		return (ptr == PtrLast) ? '0 : ptr + 1'b1;
	endfunction

	assign notEmpty  = (count != '0);
	assign doPop     = pop && notEmpty;  // Ignore pop on empty
	assign headFrame = entries[rdPtr];

	always_ff @(posedge clk) begin
		if (push) begin
			entries[wrPtr] <= pushFrame;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wrPtr <= nextPtr(wrPtr);
			end
			if (doPop) begin
				rdPtr <= nextPtr(rdPtr);
			end
			case ({push, doPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // Both or neither
			endcase
		end
	end

endmodule

// ==== design/linkSerializer.sv ====
`timescale 1ns/1ps

module linkSerializer (
	input  logic                clk,
	input  logic                rst,
	input  scanPkg::linkFrame_t headFrame,
	input  logic                notEmpty,
	output logic                pop,
	output logic                clkOut,
	output logic                dataOut
);

	logic        active;
	logic [3:0]  bitsLeft;  // Bits still to send after the current one
	logic [15:0] shiftReg;
	logic [15:0] loadWord;

	// Command byte goes out first, both bytes LSB first
	assign loadWord = {headFrame.payload, headFrame.cmd};
	assign pop      = !active && notEmpty;

	always_ff @(posedge clk) begin
		if (rst) begin
			active   <= 1'b0;
			bitsLeft <= '0;
			clkOut   <= 1'b0;
			dataOut  <= 1'b0;
		end else if (pop) begin
			active   <= 1'b1;
			bitsLeft <= headFrame.isData ? 4'd15 : 4'd7;
			clkOut   <= 1'b1;
			dataOut  <= loadWord[0];
		end else if (active && (bitsLeft != '0)) begin
			bitsLeft <= bitsLeft - 1'b1;
			clkOut   <= 1'b1;
			dataOut  <= shiftReg[0];
		end else begin
			// Idle cycle after the last bit, pop can follow here
			active  <= 1'b0;
			clkOut  <= 1'b0;
			dataOut <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			shiftReg <= {1'b0, loadWord[15:1]};  // Bit 0 already on dataOut
		end else if (active) begin
			shiftReg <= {1'b0, shiftReg[15:1]};
		end
	end

endmodule

// ==== design/scanController.sv ====
`timescale 1ns/1ps
`include "scanLink_defines.svh"

module scanController (
	input  logic                clk,
	input  logic                rst,
	input  scanPkg::hostCode_e  hostCode,
	input  logic                readyForTransfer,
	input  scanPkg::fillLevel_t fillLevel,
	input  logic                fillStep,
	output logic                countEnable,
	output logic                bufferClear,
	output logic                frameValid,
	output scanPkg::linkFrame_t frame
);
	import scanPkg::*;

	scanState_e state;
	scanState_e nextState;
	logic       cmdPush;       // Threshold command due this cycle
	linkCmd_e   cmdSel;
	logic       enterTransfer; // First cycle in TRANSFER

	always_comb begin
		nextState = state;
		cmdPush   = 1'b0;
		cmdSel    = CMD_NEAR_FULL;
		case (state)
			IDLE: begin
				if (hostCode == HOST_START) begin
					nextState = ACTIVE;
				end
			end
			ACTIVE: begin
				if (fillStep) begin
					if (fillLevel == `FILL_NEAR) begin
						cmdPush = 1'b1;
						cmdSel  = CMD_NEAR_FULL;
					end else if (fillLevel == `FILL_ALMOST) begin
						cmdPush = 1'b1;
						cmdSel  = CMD_ALMOST_FULL;
					end else if (fillLevel == `FILL_FULL) begin
						cmdPush   = 1'b1;
						cmdSel    = CMD_FULL;
						nextState = readyForTransfer ? TRANSFER : STANDBY;
					end
				end
			end
			STANDBY: begin
				// Wait for the receiver or for the peer buffer to reach half
				if (readyForTransfer || (hostCode == HOST_PEER_HALF)) begin
					nextState = TRANSFER;
				end
			end
			TRANSFER: begin
				if (hostCode == HOST_PEER_HALF) begin
					nextState = IDLE;
				end
			end
		endcase
	end

	assign countEnable = (state == ACTIVE);
	assign bufferClear = (state == TRANSFER) && (hostCode == HOST_PEER_HALF);

	always_ff @(posedge clk) begin
		if (rst) begin
			state         <= IDLE;
			enterTransfer <= 1'b0;
			frameValid    <= 1'b0;
		end else begin
			state         <= nextState;
			enterTransfer <= (nextState == TRANSFER) && (state != TRANSFER);
			frameValid    <= cmdPush || enterTransfer;
		end
	end

	// Frame register, the data frame follows CMD_FULL one cycle later
	always_ff @(posedge clk) begin
		if (enterTransfer) begin
			frame.isData  <= 1'b1;
			frame.cmd     <= CMD_DATA;
			frame.payload <= {4'b0, fillLevel};  // Level still intact when clearing
		end else if (cmdPush) begin
			frame.isData  <= 1'b0;
			frame.cmd     <= cmdSel;
			frame.payload <= '0;
		end
	end

endmodule

// ==== design/scanLink.sv ====
`timescale 1ns/1ps

module scanLink (
	input  logic               clk,
	input  logic               rst,
	input  scanPkg::hostCode_e hostCode,
	input  logic               readyForTransfer,
	output logic               clkOut,
	output logic               dataOut
);
	import scanPkg::*;

	fillLevel_t fillLevel;
	logic       fillStep;
	logic       countEnable;
	logic       bufferClear;
	logic       frameValid;
	linkFrame_t frame;
	linkFrame_t headFrame;
	logic       notEmpty;
	logic       pop;

	fillCounter fillCounterInst (
		.clk         (clk),
		.rst         (rst),
		.countEnable (countEnable),
		.bufferClear (bufferClear),
		.fillLevel   (fillLevel),
		.fillStep    (fillStep)
	);

	scanController scanControllerInst (
		.clk              (clk),
		.rst              (rst),
		.hostCode         (hostCode),
		.readyForTransfer (readyForTransfer),
		.fillLevel        (fillLevel),
		.fillStep         (fillStep),
		.countEnable      (countEnable),
		.bufferClear      (bufferClear),
		.frameValid       (frameValid),
		.frame            (frame)
	);

	frameQueue frameQueueInst (
		.clk       (clk),
		.rst       (rst),
		.push      (frameValid),
		.pushFrame (frame),
		.pop       (pop),
		.headFrame (headFrame),
		.notEmpty  (notEmpty)
	);

	linkSerializer linkSerializerInst (
		.clk       (clk),
		.rst       (rst),
		.headFrame (headFrame),
		.notEmpty  (notEmpty),
		.pop       (pop),
		.clkOut    (clkOut),
		.dataOut   (dataOut)
	);

endmodule

// ==== design/scanPkg.sv ====
package scanPkg;

	typedef logic [3:0] fillLevel_t;

	// Host input levels
	typedef enum logic [1:0] {
		HOST_NONE      = 2'd0,
		HOST_START     = 2'd1,
		HOST_PEER_HALF = 2'd2  // Peer buffer at half
	} hostCode_e;

	typedef enum logic [1:0] {
		IDLE,
		ACTIVE,
		STANDBY,
		TRANSFER
	} scanState_e;

	// Command byte sent first in every frame
	typedef enum logic [7:0] {
		CMD_NEAR_FULL   = 8'd2,
		CMD_ALMOST_FULL = 8'd3,
		CMD_FULL        = 8'd4,
		CMD_DATA        = 8'd7
	} linkCmd_e;

	typedef struct packed {
		logic       isData;   // 16-bit frame when set
		linkCmd_e   cmd;
		logic [7:0] payload;  // Only sent with data frames
	} linkFrame_t;

endpackage

// ==== scanLink.f ====
+incdir+.
design/scanPkg.sv
design/fillCounter.sv
design/scanController.sv
design/frameQueue.sv
design/linkSerializer.sv
design/scanLink.sv
testbench/scanLinkTb.sv

// ==== scanLink_defines.svh ====
`ifndef SCAN_LINK_DEFINES_SVH
`define SCAN_LINK_DEFINES_SVH

// Buffer fill rate, in clock cycles per fill step
`define SLOW_DIV 8

// Fill levels that trigger a command frame
`define FILL_NEAR   4'd7  // Near full
`define FILL_ALMOST 4'd8  // Almost full
`define FILL_FULL   4'd9  // Full, fill level saturates here

// Frames held between controller and serializer
`define QUEUE_DEPTH 4

`endif

// ==== testbench/scanLinkStimulus.txt ====
// Five hex words per record. Drive: 1 rst hostCode readyForTransfer holdCycles
// Expect: 2 isData cmd payload 0. A type 0 record ends the list
1 1 0 0 0008
1 0 0 0 0028
// Reset lands inside the first near-full frame, then the link stays quiet
1 0 1 0 0004
1 0 0 0 003b
1 1 0 0 0008
1 0 0 0 0028
// Receiver ready at full
1 0 1 1 0004
1 0 0 1 0078
2 0 02 00 0
2 0 03 00 0
2 0 04 00 0
2 1 07 09 0
1 0 2 0 0004
1 0 0 0 0008
// Standby left when the receiver becomes ready
1 0 1 0 0004
1 0 0 0 00a0
2 0 02 00 0
2 0 03 00 0
2 0 04 00 0
1 0 0 1 0004
2 1 07 09 0
1 0 2 0 0004
1 0 0 0 0008
// Standby left by peer half, straight back to idle
1 0 1 0 0004
1 0 0 0 0096
2 0 02 00 0
2 0 03 00 0
2 0 04 00 0
1 0 2 0 0004
2 1 07 09 0
1 0 0 0 0064
0 0 0 0 0000

// ==== testbench/scanLinkTb.sv ====
`timescale 1ns/1ps

module scanLinkTb;
	import scanPkg::*;

	typedef struct packed {
		logic        rst;
		hostCode_e   host;
		logic        ready;
		logic [15:0] cycles;  // Hold length
	} driveRec_t;

	typedef struct packed {
		logic       isData;
		linkCmd_e   cmd;
		fillLevel_t payload;
	} expectRec_t;

	localparam int StimWords = 256;

	logic        clk;
	logic        rst;
	hostCode_e   hostCode;
	logic        readyForTransfer;
	logic        clkOut;
	logic        dataOut;

	logic [15:0] stimMem [StimWords];
	driveRec_t   driveQ [$];
	expectRec_t  expectQ [$];
	expectRec_t  curExpect;   // Record of the frame being received
	logic        loaded;
	logic        transferOpen; // Ready or peer half applied since the last start
	int          totalCycles;
	int          bitCount;
	logic [7:0]  shiftByte;
	logic        waitPayload;  // Command byte was CMD_DATA

	scanLink uut (
		.clk              (clk),
		.rst              (rst),
		.hostCode         (hostCode),
		.readyForTransfer (readyForTransfer),
		.clkOut           (clkOut),
		.dataOut          (dataOut)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic stopOnError(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic checkCommand(input linkCmd_e got, input linkCmd_e expected);
		if (got !== expected) begin
			stopOnError($sformatf("MISMATCH cmd got 0x%02h expected 0x%02h", got, expected));
		end
	endtask

	task automatic checkPayload(input fillLevel_t got, input fillLevel_t expected);
		if (got !== expected) begin
			stopOnError($sformatf("MISMATCH payload got 0x%01h expected 0x%01h", got, expected));
		end
	endtask

	// Five hex words per record with a type word first
	task automatic loadStimulus();
		int         idx;
		driveRec_t  drv;
		expectRec_t exp;
		idx = 0;
		$readmemh("testbench/scanLinkStimulus.txt", stimMem);
		while ((idx + 4 < StimWords) && ((stimMem[idx] == 16'h1) || (stimMem[idx] == 16'h2))) begin
			if (stimMem[idx] == 16'h1) begin
				drv.rst    = stimMem[idx + 1][0];
				drv.host   = hostCode_e'(stimMem[idx + 2][1:0]);
				drv.ready  = stimMem[idx + 3][0];
				drv.cycles = stimMem[idx + 4];
				if (drv.cycles == '0) begin
					stopOnError("A drive record in the stimulus file has a zero hold length");
				end
				driveQ.push_back(drv);
				totalCycles += drv.cycles;
			end else begin
				exp.isData  = stimMem[idx + 1][0];
				exp.cmd     = linkCmd_e'(stimMem[idx + 2][7:0]);
				exp.payload = stimMem[idx + 3][3:0];
				expectQ.push_back(exp);
			end
			idx += 5;
		end
		if (driveQ.size() == 0) begin
			stopOnError("The stimulus file holds no drive records");
		end
	endtask

	task automatic takeByte(input logic [7:0] value);
		if (waitPayload) begin
			waitPayload = 1'b0;
			if (value[7:4] != 4'h0) begin
				stopOnError("A data frame payload is wider than a fill level");
			end
			checkPayload(fillLevel_t'(value[3:0]), curExpect.payload);
		end else if (expectQ.size() == 0) begin
			stopOnError($sformatf("A frame with command 0x%02h arrived with none expected", value));
		end else begin
			curExpect = expectQ.pop_front();
			checkCommand(linkCmd_e'(value), curExpect.cmd);
			if (curExpect.isData && !transferOpen) begin
				stopOnError("A data frame arrived before the receiver was ready or a peer half");
			end
			waitPayload = curExpect.isData;  // Payload byte follows
		end
	endtask

	// Link decoder sampling away from the active edge
	initial begin
		bitCount    = 0;
		shiftByte   = '0;
		waitPayload = 1'b0;
		forever begin
			@(negedge clk);
			if (rst) begin
				bitCount    = 0;  // Frame cut off by reset is dropped
				waitPayload = 1'b0;
			end else if (clkOut) begin
				shiftByte = {dataOut, shiftByte[7:1]};  // LSB first
				bitCount++;
				if (bitCount == 8) begin
					bitCount = 0;
					takeByte(shiftByte);
				end
			end
		end
	end

	initial begin
		driveRec_t drv;
		rst              = 1'b1;
		hostCode         = HOST_NONE;
		readyForTransfer = 1'b0;
		totalCycles      = 0;
		loaded           = 1'b0;
		transferOpen     = 1'b0;
		loadStimulus();
		loaded = 1'b1;
		while (driveQ.size() > 0) begin
			drv = driveQ.pop_front();
			@(posedge clk);
			rst              <= drv.rst;
			hostCode         <= drv.host;
			readyForTransfer <= drv.ready;
			if (drv.rst || (drv.host == HOST_START)) begin
				transferOpen = !drv.rst && drv.ready;  // New pass waits for a release
			end else if (drv.ready || (drv.host == HOST_PEER_HALF)) begin
				transferOpen = 1'b1;
			end
			repeat (drv.cycles - 1) @(posedge clk);
		end
		@(posedge clk);
		if ((expectQ.size() != 0) || (bitCount != 0) || waitPayload) begin
			stopOnError($sformatf("%0d expected frames missing or a frame left incomplete",
				expectQ.size()));
		end else begin
			$display("Regression passed");
			$finish;
		end
	end

	initial begin
		int limitNs;
		wait (loaded === 1'b1);
		limitNs = totalCycles * 8 + 1000;  // Whole drive schedule plus margin
		#(limitNs);
		stopOnError("Timeout, the drive schedule did not complete");
	end

endmodule
